// File: rtl/lsq_defines.svh
`ifndef LSQ_DEFINES_SVH
`define LSQ_DEFINES_SVH

// Entries per queue
`define LSQ_DEPTH 8

// Data and address width
`define LSQ_XLEN 32

// Physical register tag and reorder-buffer index
`define LSQ_PREG_W 6
`define LSQ_ROB_W 5

// Byte lanes per word
`define LSQ_MASK_W 4

`endif

// File: rtl/lsq_pkg.sv
`include "lsq_defines.svh"

package lsq_pkg;

    typedef logic [$clog2(`LSQ_DEPTH)-1:0] lsq_ptr_t;

    // One queued load or store
    typedef struct packed {
        logic                   valid;
        logic [`LSQ_PREG_W-1:0] rs1;
        logic [`LSQ_PREG_W-1:0] rs2;
        logic                   rs1_met;
        logic                   rs2_met;
        // Peer slot that must become the peer head first
        lsq_ptr_t               order_ptr;
        logic                   order_met;
        logic [`LSQ_XLEN-1:0]   imm;
        // Unshifted lanes, 1, 3 or 15
        logic [`LSQ_MASK_W-1:0] mask;
        logic                   is_signed;
        logic [`LSQ_PREG_W-1:0] rd;
        logic [`LSQ_ROB_W-1:0]  rob_id;
    } lsq_entry_t;

    // Issue controller states
    typedef enum logic [2:0] {
        wait_load_pri,
        wait_store_pri,
        request_load,
        request_store,
        latch_load,
        latch_store
    } lsq_state_e;

endpackage

// File: rtl/lsq_head_if.sv
`include "lsq_defines.svh"

interface lsq_head_if;

    logic                ready;
    lsq_pkg::lsq_entry_t entry;
    lsq_pkg::lsq_ptr_t   alloc_ptr;
    lsq_pkg::lsq_ptr_t   oldest_ptr;
    // One-cycle pulse, only while ready
    logic                pop;

    modport queue (output ready, entry, alloc_ptr, oldest_ptr, input pop);

    modport issue (input ready, entry, output pop);

    // Seen by the queue of the other kind
    modport peer (input alloc_ptr, oldest_ptr);

endinterface

// File: rtl/mem_op_queue.sv
`include "lsq_defines.svh"

module mem_op_queue #(
    parameter bit STORE_QUEUE = 1'b0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   disp_valid,
    input  logic                   disp_is_store,
    input  logic                   disp_is_signed,
    input  logic [`LSQ_MASK_W-1:0] disp_mask,
    input  logic [`LSQ_PREG_W-1:0] disp_rs1,
    input  logic                   disp_rs1_ready,
    input  logic [`LSQ_PREG_W-1:0] disp_rs2,
    input  logic                   disp_rs2_ready,
    input  logic [`LSQ_PREG_W-1:0] disp_rd,
    input  logic [`LSQ_ROB_W-1:0]  disp_rob_id,
    input  logic [`LSQ_XLEN-1:0]   disp_imm,
    input  logic                   cdb_valid,
    input  logic [`LSQ_PREG_W-1:0] cdb_tag,
    output logic                   full,
    lsq_head_if.queue              head,
    lsq_head_if.peer               peer
);

    localparam int CNT_W = $clog2(`LSQ_DEPTH) + 1;

    lsq_pkg::lsq_entry_t slots [`LSQ_DEPTH];
    lsq_pkg::lsq_entry_t new_entry;
    lsq_pkg::lsq_ptr_t   head_ptr;
    lsq_pkg::lsq_ptr_t   tail_ptr;
    logic [CNT_W-1:0]    count;
    logic                push;

    assign full = (count == CNT_W'(`LSQ_DEPTH));
    assign push = disp_valid && (disp_is_store == STORE_QUEUE) && !full;

    // Sources already on the CDB count as met
    always_comb begin
        new_entry           = '0;
        new_entry.valid     = 1'b1;
        new_entry.rs1       = disp_rs1;
        new_entry.rs2       = disp_rs2;
        new_entry.rs1_met   = disp_rs1_ready || (cdb_valid && cdb_tag == disp_rs1);
        new_entry.rs2_met   = STORE_QUEUE ? (disp_rs2_ready || (cdb_valid && cdb_tag == disp_rs2))
                                          : 1'b1;
        new_entry.order_ptr = peer.alloc_ptr;
        // Nothing older in the peer queue
        new_entry.order_met = (peer.oldest_ptr == peer.alloc_ptr);
        new_entry.imm       = disp_imm;
        new_entry.mask      = disp_mask;
        new_entry.is_signed = disp_is_signed;
        new_entry.rd        = disp_rd;
        new_entry.rob_id    = disp_rob_id;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (head.pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (push && !head.pop) begin
                count <= count + 1'b1;
            end else if (!push && head.pop) begin
                count <= count - 1'b1;
            end
        end
    end

    // Entry storage with wakeup and ordering
    always_ff @(posedge clk) begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            if (rst || flush) begin
                slots[i].valid <= 1'b0;
            end else if (push && tail_ptr == lsq_pkg::lsq_ptr_t'(i)) begin
                slots[i] <= new_entry;
            end else if (slots[i].valid) begin
                if (cdb_valid && slots[i].rs1 == cdb_tag) begin
                    slots[i].rs1_met <= 1'b1;
                end
                if (cdb_valid && slots[i].rs2 == cdb_tag) begin
                    slots[i].rs2_met <= 1'b1;
                end
                if (peer.oldest_ptr == slots[i].order_ptr) begin
                    slots[i].order_met <= 1'b1;
                end
                if (head.pop && head_ptr == lsq_pkg::lsq_ptr_t'(i)) begin
                    slots[i].valid <= 1'b0;
                end
            end
        end
    end

    // rs2_met is forced for loads
    assign head.ready      = slots[head_ptr].valid && slots[head_ptr].rs1_met &&
                             slots[head_ptr].rs2_met && slots[head_ptr].order_met;
    assign head.entry      = slots[head_ptr];
    assign head.alloc_ptr  = tail_ptr;
    assign head.oldest_ptr = head_ptr;

    a_pop_when_ready: assert property (
        @(posedge clk) disable iff (rst)
        head.pop |-> head.ready
    );

    // Occupancy never passes the depth and matches the pointers
    a_count_consistent: assert property (
        @(posedge clk) disable iff (rst)
        (count <= CNT_W'(`LSQ_DEPTH)) &&
        (tail_ptr == lsq_pkg::lsq_ptr_t'(head_ptr + count[CNT_W-2:0]))
    );

endmodule

// File: rtl/lsq_issue_ctrl.sv
`include "lsq_defines.svh"

module lsq_issue_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            flush,
    input  logic                            store_commit,
    lsq_head_if.issue                       load_head,
    lsq_head_if.issue                       store_head,
    output logic [`LSQ_PREG_W-1:0]          rf_rs1,
    output logic [`LSQ_PREG_W-1:0]          rf_rs2,
    input  logic [`LSQ_XLEN-1:0]            rf_rs1_data,
    input  logic [`LSQ_XLEN-1:0]            rf_rs2_data,
    output logic [`LSQ_XLEN-1:0]            dmem_addr,
    output logic [`LSQ_MASK_W-1:0]          dmem_rmask,
    output logic [`LSQ_MASK_W-1:0]          dmem_wmask,
    output logic [`LSQ_XLEN-1:0]            dmem_wdata,
    input  logic                            dmem_resp,
    output lsq_pkg::lsq_entry_t             entry,
    output logic [$clog2(`LSQ_MASK_W)-1:0]  byte_offset,
    output logic                            result_send
);

    localparam int OFF_W = $clog2(`LSQ_MASK_W);

    lsq_pkg::lsq_state_e state;
    lsq_pkg::lsq_state_e next_state;
    lsq_pkg::lsq_entry_t sel_entry;
    lsq_pkg::lsq_entry_t issue_entry;
    logic                in_wait;
    logic                in_request;
    logic                in_latch;
    logic                load_ok;
    logic                store_ok;
    logic                take_load;
    logic                take_store;
    logic                block;
    logic [`LSQ_XLEN-1:0]   eff_addr;
    logic [`LSQ_XLEN-1:0]   addr_q;
    logic [`LSQ_XLEN-1:0]   wdata_q;
    logic [`LSQ_MASK_W-1:0] rmask_q;
    logic [`LSQ_MASK_W-1:0] wmask_q;

    assign in_wait    = (state == lsq_pkg::wait_load_pri) || (state == lsq_pkg::wait_store_pri);
    assign in_request = (state == lsq_pkg::request_load) || (state == lsq_pkg::request_store);
    assign in_latch   = (state == lsq_pkg::latch_load) || (state == lsq_pkg::latch_store);

    assign load_ok  = load_head.ready;
    assign store_ok = store_head.ready && store_commit;

    // Favored kind wins a tie
    assign take_load  = in_wait && !flush && load_ok &&
                        (state == lsq_pkg::wait_load_pri || !store_ok);
    assign take_store = in_wait && !flush && store_ok && !take_load;

    assign load_head.pop  = take_load;
    assign store_head.pop = take_store;

    assign sel_entry = take_store ? store_head.entry : load_head.entry;
    assign rf_rs1    = sel_entry.rs1;
    assign rf_rs2    = sel_entry.rs2;
    assign eff_addr  = rf_rs1_data + sel_entry.imm;

    // Stores return no destination and no lanes
    always_comb begin
        issue_entry = sel_entry;
        if (take_store) begin
            issue_entry.rd        = '0;
            issue_entry.mask      = '0;
            issue_entry.is_signed = 1'b0;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            lsq_pkg::wait_load_pri, lsq_pkg::wait_store_pri: begin
                if (take_load) begin
                    next_state = lsq_pkg::request_load;
                end else if (take_store) begin
                    next_state = lsq_pkg::request_store;
                end
            end
            lsq_pkg::request_load: begin
                if (dmem_resp) begin
                    next_state = lsq_pkg::latch_load;
                end
            end
            lsq_pkg::request_store: begin
                if (dmem_resp) begin
                    next_state = lsq_pkg::latch_store;
                end
            end
            lsq_pkg::latch_load:  next_state = lsq_pkg::wait_store_pri;
            lsq_pkg::latch_store: next_state = lsq_pkg::wait_load_pri;
            default:              next_state = lsq_pkg::wait_load_pri;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lsq_pkg::wait_load_pri;
            block <= 1'b0;
        end else begin
            state <= next_state;
            if (flush && in_request) begin
                block <= 1'b1;
            end else if (!in_request) begin
                block <= 1'b0;
            end
        end
    end

    // Request payload, held until the response
    always_ff @(posedge clk) begin
        if (take_load || take_store) begin
            addr_q      <= {eff_addr[`LSQ_XLEN-1:OFF_W], {OFF_W{1'b0}}};
            byte_offset <= eff_addr[OFF_W-1:0];
            rmask_q     <= take_load ? sel_entry.mask << eff_addr[OFF_W-1:0] : '0;
            wmask_q     <= take_store ? sel_entry.mask << eff_addr[OFF_W-1:0] : '0;
            wdata_q     <= rf_rs2_data << {eff_addr[OFF_W-1:0], 3'b000};
            entry       <= issue_entry;
        end
    end

    assign dmem_addr   = addr_q;
    assign dmem_wdata  = wdata_q;
    assign dmem_rmask  = (state == lsq_pkg::request_load) ? rmask_q : '0;
    assign dmem_wmask  = (state == lsq_pkg::request_store) ? wmask_q : '0;
    assign result_send = in_latch && !block;

    a_req_stable: assert property (
        @(posedge clk) disable iff (rst)
        (in_request && !dmem_resp) |=> $stable({dmem_addr, dmem_rmask, dmem_wmask, dmem_wdata})
    );

    // A request carries lanes in exactly one direction
    a_one_direction: assert property (
        @(posedge clk) disable iff (rst)
        in_request |-> ((|dmem_rmask) != (|dmem_wmask))
    );

endmodule

// File: rtl/lsq_load_format.sv
`include "lsq_defines.svh"

module lsq_load_format (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [`LSQ_XLEN-1:0]           dmem_rdata,
    input  logic                           dmem_resp,
    input  lsq_pkg::lsq_entry_t            entry,
    input  logic [$clog2(`LSQ_MASK_W)-1:0] byte_offset,
    input  logic                           result_send,
    output logic                           cdb_out_valid,
    output logic [`LSQ_PREG_W-1:0]         cdb_out_tag,
    output logic [`LSQ_ROB_W-1:0]          cdb_out_rob_id,
    output logic [`LSQ_XLEN-1:0]           cdb_out_data
);

    logic [`LSQ_XLEN-1:0] shifted;
    logic [`LSQ_XLEN-1:0] aligned;
    logic [`LSQ_XLEN-1:0] load_data_q;
    logic                 sign_bit;

    always_comb begin
        shifted  = dmem_rdata >> {byte_offset, 3'b000};
        sign_bit = 1'b0;
        // Top kept lane gives the sign
        for (int i = 0; i < `LSQ_MASK_W; i++) begin
            if (entry.mask[i]) begin
                sign_bit = entry.is_signed & shifted[8*i+7];
            end
        end
        aligned = shifted;
        for (int i = 0; i < `LSQ_MASK_W; i++) begin
            if (!entry.mask[i]) begin
                aligned[8*i +: 8] = {8{sign_bit}};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            load_data_q <= '0;
        end else if (dmem_resp) begin
            load_data_q <= aligned;
        end
    end

    assign cdb_out_valid  = result_send;
    assign cdb_out_tag    = entry.rd;
    assign cdb_out_rob_id = entry.rob_id;
    assign cdb_out_data   = load_data_q;

endmodule

// File: rtl/load_store_queue.sv
`include "lsq_defines.svh"

module load_store_queue (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   disp_valid,
    input  logic                   disp_is_store,
    input  logic                   disp_is_signed,
    input  logic [`LSQ_MASK_W-1:0] disp_mask,
    input  logic [`LSQ_PREG_W-1:0] disp_rs1,
    input  logic                   disp_rs1_ready,
    input  logic [`LSQ_PREG_W-1:0] disp_rs2,
    input  logic                   disp_rs2_ready,
    input  logic [`LSQ_PREG_W-1:0] disp_rd,
    input  logic [`LSQ_ROB_W-1:0]  disp_rob_id,
    input  logic [`LSQ_XLEN-1:0]   disp_imm,
    output logic                   load_full,
    output logic                   store_full,
    input  logic                   cdb_valid,
    input  logic [`LSQ_PREG_W-1:0] cdb_tag,
    input  logic                   store_commit,
    output logic [`LSQ_PREG_W-1:0] rf_rs1,
    output logic [`LSQ_PREG_W-1:0] rf_rs2,
    input  logic [`LSQ_XLEN-1:0]   rf_rs1_data,
    input  logic [`LSQ_XLEN-1:0]   rf_rs2_data,
    output logic [`LSQ_XLEN-1:0]   dmem_addr,
    output logic [`LSQ_MASK_W-1:0] dmem_rmask,
    output logic [`LSQ_MASK_W-1:0] dmem_wmask,
    output logic [`LSQ_XLEN-1:0]   dmem_wdata,
    input  logic [`LSQ_XLEN-1:0]   dmem_rdata,
    input  logic                   dmem_resp,
    output logic                   cdb_out_valid,
    output logic [`LSQ_PREG_W-1:0] cdb_out_tag,
    output logic [`LSQ_ROB_W-1:0]  cdb_out_rob_id,
    output logic [`LSQ_XLEN-1:0]   cdb_out_data
);

    lsq_pkg::lsq_entry_t                  issued_entry;
    logic [$clog2(`LSQ_MASK_W)-1:0]       byte_offset;
    logic                                 result_send;

    lsq_head_if load_if ();
    lsq_head_if store_if ();

    mem_op_queue #(.STORE_QUEUE(1'b0)) u_load_queue (
        .clk, .rst, .flush, .disp_valid, .disp_is_store, .disp_is_signed, .disp_mask,
        .disp_rs1, .disp_rs1_ready, .disp_rs2, .disp_rs2_ready, .disp_rd, .disp_rob_id,
        .disp_imm, .cdb_valid, .cdb_tag, .full(load_full),
        .head(load_if.queue), .peer(store_if.peer)
    );

    mem_op_queue #(.STORE_QUEUE(1'b1)) u_store_queue (
        .clk, .rst, .flush, .disp_valid, .disp_is_store, .disp_is_signed, .disp_mask,
        .disp_rs1, .disp_rs1_ready, .disp_rs2, .disp_rs2_ready, .disp_rd, .disp_rob_id,
        .disp_imm, .cdb_valid, .cdb_tag, .full(store_full),
        .head(store_if.queue), .peer(load_if.peer)
    );

    lsq_issue_ctrl u_issue (
        .clk, .rst, .flush, .store_commit,
        .load_head(load_if.issue), .store_head(store_if.issue),
        .rf_rs1, .rf_rs2, .rf_rs1_data, .rf_rs2_data,
        .dmem_addr, .dmem_rmask, .dmem_wmask, .dmem_wdata, .dmem_resp,
        .entry(issued_entry), .byte_offset, .result_send
    );

    lsq_load_format u_format (
        .clk, .rst, .dmem_rdata, .dmem_resp, .entry(issued_entry), .byte_offset,
        .result_send, .cdb_out_valid, .cdb_out_tag, .cdb_out_rob_id, .cdb_out_data
    );

endmodule

// File: tb/tb_load_store_queue.sv
`include "lsq_defines.svh"

module tb_load_store_queue;

    timeunit 1ns;
    timeprecision 1ps;

    logic                   clk;
    logic                   rst;
    logic                   flush;
    logic                   disp_valid;
    logic                   disp_is_store;
    logic                   disp_is_signed;
    logic [`LSQ_MASK_W-1:0] disp_mask;
    logic [`LSQ_PREG_W-1:0] disp_rs1;
    logic                   disp_rs1_ready;
    logic [`LSQ_PREG_W-1:0] disp_rs2;
    logic                   disp_rs2_ready;
    logic [`LSQ_PREG_W-1:0] disp_rd;
    logic [`LSQ_ROB_W-1:0]  disp_rob_id;
    logic [`LSQ_XLEN-1:0]   disp_imm;
    logic                   load_full;
    logic                   store_full;
    logic                   cdb_valid;
    logic [`LSQ_PREG_W-1:0] cdb_tag;
    logic                   store_commit;
    logic [`LSQ_PREG_W-1:0] rf_rs1;
    logic [`LSQ_PREG_W-1:0] rf_rs2;
    logic [`LSQ_XLEN-1:0]   rf_rs1_data;
    logic [`LSQ_XLEN-1:0]   rf_rs2_data;
    logic [`LSQ_XLEN-1:0]   dmem_addr;
    logic [`LSQ_MASK_W-1:0] dmem_rmask;
    logic [`LSQ_MASK_W-1:0] dmem_wmask;
    logic [`LSQ_XLEN-1:0]   dmem_wdata;
    logic [`LSQ_XLEN-1:0]   dmem_rdata = '0;
    logic                   dmem_resp = 1'b0;
    logic                   cdb_out_valid;
    logic [`LSQ_PREG_W-1:0] cdb_out_tag;
    logic [`LSQ_ROB_W-1:0]  cdb_out_rob_id;
    logic [`LSQ_XLEN-1:0]   cdb_out_data;

    logic [`LSQ_XLEN-1:0]   mem [256];
    logic [`LSQ_XLEN-1:0]   regs [64];
    logic                   mem_busy = 1'b0;
    logic                   mem_hold = 1'b0;
    int unsigned            mem_delay = 0;
    int                     access_seq = 0;
    int                     last_read_seq = 0;
    int                     last_write_seq = 0;
    logic [`LSQ_XLEN-1:0]   last_read_addr = '0;
    logic [`LSQ_MASK_W-1:0] last_rmask = '0;
    logic [`LSQ_XLEN-1:0]   last_write_addr = '0;
    logic [`LSQ_MASK_W-1:0] last_wmask = '0;
    logic [`LSQ_XLEN-1:0]   last_wdata = '0;
    logic [`LSQ_PREG_W-1:0] res_tag [$];
    logic [`LSQ_ROB_W-1:0]  res_rob [$];
    logic [`LSQ_XLEN-1:0]   res_data [$];
    int                     checks = 0;
    int                     errors = 0;

    load_store_queue u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assign rf_rs1_data = regs[rf_rs1];
    assign rf_rs2_data = regs[rf_rs2];

    // Word index sets every byte
    function automatic logic [31:0] mem_fill(input logic [7:0] idx);
        return {idx, idx ^ 8'hFF, idx * 8'd3, idx ^ 8'h5A};
    endfunction

    function automatic logic [31:0] expect_load(input logic [31:0] word, input int off,
                                                input int size, input bit sgn);
        logic [31:0] v;
        v = word >> (8 * off);
        case (size)
            1: return sgn ? {{24{v[7]}}, v[7:0]} : {24'h0, v[7:0]};
            2: return sgn ? {{16{v[15]}}, v[15:0]} : {16'h0, v[15:0]};
            default: return v;
        endcase
    endfunction

    task automatic serve_access();
        logic [7:0] idx;
        idx = dmem_addr[9:2];
        access_seq++;
        dmem_rdata = mem[idx];
        if (dmem_wmask != 0) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_wmask[b]) begin
                    mem[idx][8*b +: 8] = dmem_wdata[8*b +: 8];
                end
            end
            last_write_seq  = access_seq;
            last_write_addr = dmem_addr;
            last_wmask      = dmem_wmask;
            last_wdata      = dmem_wdata;
        end else begin
            last_read_seq  = access_seq;
            last_read_addr = dmem_addr;
            last_rmask     = dmem_rmask;
        end
        dmem_resp = 1'b1;
    endtask

    // Data memory with 0 to 3 cycles of latency
    always @(negedge clk) begin
        dmem_resp = 1'b0;
        if (rst) begin
            mem_busy = 1'b0;
        end else begin
            if (!mem_busy && (dmem_rmask != 0 || dmem_wmask != 0)) begin
                mem_busy  = 1'b1;
                mem_delay = $urandom % 4;
            end
            if (mem_busy && !mem_hold) begin
                if (mem_delay == 0) begin
                    serve_access();
                    mem_busy = 1'b0;
                end else begin
                    mem_delay--;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && cdb_out_valid) begin
            res_tag.push_back(cdb_out_tag);
            res_rob.push_back(cdb_out_rob_id);
            res_data.push_back(cdb_out_data);
        end
    end

    task automatic note_fail(input string msg);
        errors++;
        $display("FAIL %0t ns: %s", $time, msg);
    endtask

    task automatic check_word(input string what, input logic [`LSQ_XLEN-1:0] got,
                              input logic [`LSQ_XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            note_fail($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_tag(input string what, input logic [`LSQ_PREG_W-1:0] got,
                             input logic [`LSQ_PREG_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            note_fail($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_rob(input string what, input logic [`LSQ_ROB_W-1:0] got,
                             input logic [`LSQ_ROB_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            note_fail($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_mask(input string what, input logic [`LSQ_MASK_W-1:0] got,
                              input logic [`LSQ_MASK_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            note_fail($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            note_fail($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    // Called and left at a falling edge
    task automatic dispatch(input logic is_store, input logic sgn,
                            input logic [`LSQ_MASK_W-1:0] mask,
                            input logic [`LSQ_PREG_W-1:0] rs1, input logic rs1_rdy,
                            input logic [`LSQ_PREG_W-1:0] rs2, input logic rs2_rdy,
                            input logic [`LSQ_PREG_W-1:0] rd,
                            input logic [`LSQ_ROB_W-1:0] rob,
                            input logic [`LSQ_XLEN-1:0] imm);
        disp_valid     = 1'b1;
        disp_is_store  = is_store;
        disp_is_signed = sgn;
        disp_mask      = mask;
        disp_rs1       = rs1;
        disp_rs1_ready = rs1_rdy;
        disp_rs2       = rs2;
        disp_rs2_ready = rs2_rdy;
        disp_rd        = rd;
        disp_rob_id    = rob;
        disp_imm       = imm;
        @(negedge clk);
        disp_valid = 1'b0;
        cdb_valid  = 1'b0;
    endtask

    task automatic broadcast(input logic [`LSQ_PREG_W-1:0] tag);
        cdb_valid = 1'b1;
        cdb_tag   = tag;
        @(negedge clk);
        cdb_valid = 1'b0;
    endtask

    task automatic wait_results(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (res_data.size() < n && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (res_data.size() < n) begin
            errors++;
            $display("Timed out after %0d cycles waiting for %0d CDB results, got %0d",
                     limit, n, res_data.size());
        end
    endtask

    task automatic wait_request(input int limit);
        int cycles;
        cycles = 0;
        while (dmem_rmask == 0 && dmem_wmask == 0 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (dmem_rmask == 0 && dmem_wmask == 0) begin
            errors++;
            $display("Timed out after %0d cycles waiting for a memory request", limit);
        end
    endtask

    task automatic expect_no_request(input int cycles, input string what);
        repeat (cycles) begin
            if (dmem_rmask != 0 || dmem_wmask != 0) begin
                note_fail($sformatf("%s made a memory request too early", what));
            end
            @(negedge clk);
        end
    endtask

    task automatic expect_result(input string what, input logic [`LSQ_PREG_W-1:0] tag,
                                 input logic [`LSQ_ROB_W-1:0] rob,
                                 input logic [`LSQ_XLEN-1:0] data);
        wait_results(1, 200);
        if (res_data.size() > 0) begin
            check_tag({what, " tag"}, res_tag.pop_front(), tag);
            check_rob({what, " rob_id"}, res_rob.pop_front(), rob);
            check_word({what, " data"}, res_data.pop_front(), data);
        end
    endtask

    task automatic test_word_load();
        dispatch(1'b0, 1'b0, 4'hF, 6'd1, 1'b1, 6'd0, 1'b0, 6'd10, 5'd3, 32'h20);
        expect_result("word load", 6'd10, 5'd3, mem_fill(8'h48));
        check_word("word load addr", last_read_addr, 32'h120);
        check_mask("word load rmask", last_rmask, 4'hF);
    endtask

    task automatic test_sub_word_loads();
        logic [`LSQ_ROB_W-1:0] rob;
        for (int off = 0; off < 4; off++) begin
            for (int sgn = 0; sgn < 2; sgn++) begin
                rob = 5'(off * 2 + sgn);
                dispatch(1'b0, sgn[0], 4'h1, 6'd1, 1'b1, 6'd0, 1'b0, 6'd11, rob, 32'h3C + off);
                expect_result("byte load", 6'd11, rob,
                              expect_load(mem_fill(8'h4F), off, 1, sgn[0]));
                check_mask("byte load rmask", last_rmask, 4'h1 << off);
                if (off % 2 == 0) begin
                    dispatch(1'b0, sgn[0], 4'h3, 6'd1, 1'b1, 6'd0, 1'b0, 6'd12, rob,
                             32'h3C + off);
                    expect_result("half load", 6'd12, rob,
                                  expect_load(mem_fill(8'h4F), off, 2, sgn[0]));
                    check_mask("half load rmask", last_rmask, 4'h3 << off);
                end
            end
        end
    endtask

    task automatic test_store_then_load();
        logic [`LSQ_XLEN-1:0] merged;
        merged        = mem_fill(8'h50);
        merged[31:16] = 16'hBEEF;
        store_commit  = 1'b0;
        // A store broadcasts tag 0 whatever rd it carries
        dispatch(1'b1, 1'b0, 4'h3, 6'd1, 1'b1, 6'd2, 1'b1, 6'd17, 5'd12, 32'h42);
        dispatch(1'b0, 1'b0, 4'hF, 6'd1, 1'b1, 6'd0, 1'b0, 6'd13, 5'd13, 32'h40);
        expect_no_request(6, "uncommitted store");
        store_commit = 1'b1;
        expect_result("store", 6'd0, 5'd12, 32'h0);
        expect_result("load after store", 6'd13, 5'd13, merged);
        check_word("store addr", last_write_addr, 32'h140);
        check_mask("store wmask", last_wmask, 4'hC);
        check_word("store wdata", last_wdata, 32'hBEEF_0000);
        check_flag("load read after store write", last_read_seq > last_write_seq, 1'b1);
    endtask

    task automatic test_wakeup();
        dispatch(1'b0, 1'b0, 4'hF, 6'd5, 1'b0, 6'd0, 1'b0, 6'd14, 5'd14, 32'h10);
        expect_no_request(6, "load with unready rs1");
        broadcast(6'd5);
        expect_result("woken load", 6'd14, 5'd14, mem_fill(8'h84));
        // Tag on the CDB in the dispatch cycle
        cdb_valid = 1'b1;
        cdb_tag   = 6'd6;
        dispatch(1'b0, 1'b0, 4'hF, 6'd6, 1'b0, 6'd0, 1'b0, 6'd15, 5'd15, 32'h4);
        expect_result("load woken at dispatch", 6'd15, 5'd15, mem_fill(8'hA1));
    endtask

    task automatic test_full_queue();
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            dispatch(1'b0, 1'b0, 4'hF, 6'd7, 1'b0, 6'd0, 1'b0, 6'(16 + i), 5'(16 + i),
                     32'(4 * i));
        end
        check_flag("load_full after eight loads", load_full, 1'b1);
        dispatch(1'b0, 1'b0, 4'hF, 6'd7, 1'b0, 6'd0, 1'b0, 6'd31, 5'd31, 32'h40);
        check_flag("load_full after dropped load", load_full, 1'b1);
        broadcast(6'd7);
        wait_results(`LSQ_DEPTH, 400);
        repeat (40) @(negedge clk);
        check_word("results after full queue", 32'(res_data.size()), 32'(`LSQ_DEPTH));
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            expect_result("queued load", 6'(16 + i), 5'(16 + i), mem_fill(8'(8'hC0 + i)));
        end
    endtask

    task automatic test_flush_pending();
        res_tag.delete();
        res_rob.delete();
        res_data.delete();
        mem_hold = 1'b1;
        dispatch(1'b0, 1'b0, 4'hF, 6'd1, 1'b1, 6'd0, 1'b0, 6'd20, 5'd20, 32'h80);
        wait_request(50);
        dispatch(1'b0, 1'b0, 4'hF, 6'd9, 1'b0, 6'd0, 1'b0, 6'd21, 5'd21, 32'h0);
        dispatch(1'b1, 1'b0, 4'hF, 6'd9, 1'b0, 6'd2, 1'b1, 6'd0, 5'd22, 32'h0);
        flush = 1'b1;
        @(negedge clk);
        flush    = 1'b0;
        mem_hold = 1'b0;
        repeat (20) @(negedge clk);
        check_word("results after flush", 32'(res_data.size()), 32'h0);
        broadcast(6'd9);
        expect_no_request(10, "flushed entry");
        check_word("results after flushed wakeup", 32'(res_data.size()), 32'h0);
        check_flag("load_full after flush", load_full, 1'b0);
        check_flag("store_full after flush", store_full, 1'b0);
        dispatch(1'b0, 1'b0, 4'hF, 6'd1, 1'b1, 6'd0, 1'b0, 6'd23, 5'd23, 32'h84);
        expect_result("load after flush", 6'd23, 5'd23, mem_fill(8'h61));
    endtask

    initial begin
        void'($urandom(32'h768d_0f09));
        rst            = 1'b1;
        flush          = 1'b0;
        disp_valid     = 1'b0;
        disp_is_store  = 1'b0;
        disp_is_signed = 1'b0;
        disp_mask      = '0;
        disp_rs1       = '0;
        disp_rs1_ready = 1'b0;
        disp_rs2       = '0;
        disp_rs2_ready = 1'b0;
        disp_rd        = '0;
        disp_rob_id    = '0;
        disp_imm       = '0;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        store_commit   = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = mem_fill(8'(i));
        end
        for (int i = 0; i < 64; i++) begin
            regs[i] = '0;
        end
        regs[1] = 32'h0000_0100;
        regs[2] = 32'h1234_BEEF;
        regs[5] = 32'h0000_0200;
        regs[6] = 32'h0000_0280;
        regs[7] = 32'h0000_0300;
        regs[9] = 32'h0000_0080;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_mask("dmem_rmask after reset", dmem_rmask, 4'h0);
        check_mask("dmem_wmask after reset", dmem_wmask, 4'h0);
        check_flag("cdb_out_valid after reset", cdb_out_valid, 1'b0);
        check_flag("load_full after reset", load_full, 1'b0);
        check_flag("store_full after reset", store_full, 1'b0);
        test_word_load();
        test_sub_word_loads();
        test_store_then_load();
        test_wakeup();
        test_full_queue();
        test_flush_pending();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: lsq_top.f
+incdir+rtl
rtl/lsq_pkg.sv
rtl/lsq_head_if.sv
rtl/mem_op_queue.sv
rtl/lsq_issue_ctrl.sv
rtl/lsq_load_format.sv
rtl/load_store_queue.sv
tb/tb_load_store_queue.sv

// File: Makefile
SIM        = verilator
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_load_store_queue
RTL_TOP    = load_store_queue
FILELIST   = lsq_top.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
